// File: format_switch.sv
`timescale 1ns/1ps

module format_switch (
	input  logic                   clk50m_bufg,
	input  logic                   RSTBTN,
	input  logic [3:0]             sw,         // Raw switches, asynchronous
	output video_fmt_pkg::fmt_code_t fmt_sel,  // Settled format
	output logic                   fmt_change  // One cycle when fmt_sel moves
);

	import video_fmt_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Two-flop synchronizer
	////////////////////////////////////////////////////////////////////////////
	logic [3:0] sw_meta; // First stage, may go metastable
	logic [3:0] sw_sync; // Safe to use from here on

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Debounce
	////////////////////////////////////////////////////////////////////////////
	fmt_code_t                cand;      // Value being timed
	logic [DEBOUNCE_BITS-1:0] stab_cnt;  // Cycles cand has held
	logic                     stab_done;

	// Counter parks at all ones
	assign stab_done = &stab_cnt;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			cand     <= FMT_HDTV720P;
			stab_cnt <= '0;
		end else if (sw_sync != cand) begin
			// New setting or bounce, start over
			cand     <= sw_sync;
			stab_cnt <= '0;
		end else if (!stab_done) begin
			stab_cnt <= stab_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Format register and change pulse
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			fmt_sel    <= FMT_HDTV720P; // Boot in 720p
			fmt_change <= 1'b0;
		end else if (stab_done && sw_sync == cand) begin
			fmt_sel    <= cand;
			fmt_change <= (cand != fmt_sel); // Only once, fmt_sel catches up
		end else begin
			fmt_change <= 1'b0;
		end
	end

	// While parked, stab_done stays high every cycle
	// but the compare against fmt_sel keeps the pulse single
	// A bounce back to the old value before saturation
	// never reaches fmt_sel, nor does any code seen
	// for fewer than 2^DEBOUNCE_BITS cycles
	// Unknown codes pass through as they are
	// and the timing table maps them to 720p

endmodule

// File: list.f
video_fmt_pkg.sv
format_switch.sv
raster_gen.sv
video_out.sv
video_timing_top.sv
tb_video_timing.sv

// File: raster_gen.sv
`timescale 1ns/1ps

module raster_gen (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  video_fmt_pkg::fmt_code_t   fmt_sel,
	input  logic                       fmt_change,   // Load new timing, restart raster
	output video_fmt_pkg::raster_t     raster,       // Registered counters and flags
	output logic                       neg_polarity  // Aligned with raster
);

	import video_fmt_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Timing register and counters
	////////////////////////////////////////////////////////////////////////////
	video_timing_t    tmg;    // Timing of the format in use
	logic [CNT_W-1:0] hcount; // Pixel in line
	logic [CNT_W-1:0] vcount; // Line in frame
	logic             h_last; // Last pixel of the line
	logic             v_last; // Last line of the frame

	assign h_last = (hcount == tmg.heblnk);
	assign v_last = (vcount == tmg.veblnk);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			tmg    <= fmt_timing(FMT_HDTV720P);
			hcount <= '0;
			vcount <= '0;
		end else if (fmt_change) begin
			// New format, raster starts clean at the top left
			tmg    <= fmt_timing(fmt_sel);
			hcount <= '0;
			vcount <= '0;
		end else if (h_last) begin
			hcount <= '0;
			if (v_last)
				vcount <= '0; // Frame wrap
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Blanking and raw sync
	////////////////////////////////////////////////////////////////////////////
	// One cycle behind the counters, compares use the held timing

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			raster       <= '0;
			neg_polarity <= 1'b0; // 720p is positive
		end else begin
			raster.hcount <= hcount;
			raster.vcount <= vcount;

			// Past the active area
			raster.hblnk <= (hcount > tmg.hsblnk);
			raster.vblnk <= (vcount > tmg.vsblnk);

			// Sync window (start, end]
			raster.hsync <= (hcount > tmg.hssync) && (hcount <= tmg.hesync);
			raster.vsync <= (vcount > tmg.vssync) && (vcount <= tmg.vesync);

			// Follows the timing so polarity flips with the new raster
			neg_polarity <= tmg.neg_polarity;
		end
	end

	// The timing register only moves together with a counter restart,
	// so the compares never mix old counts with new limits
	// for more than the single cycle of the change itself
	// hsync width is hesync - hssync cycles
	// and the line has heblnk + 1 cycles in all
	// vsync counts whole lines the same way

endmodule

// File: tb_video_timing.sv
`timescale 1ns/1ps

module tb_video_timing;

	import video_fmt_pkg::*;

	localparam int EV_LINE  = 0; // De rising edge inside a frame
	localparam int EV_DE    = 1; // End of a de run
	localparam int EV_HS    = 2; // End of an hsync pulse
	localparam int EV_VS    = 3; // End of a vsync pulse
	localparam int EV_FRAME = 4; // Start of a vsync pulse

	logic        clk50m_bufg;
	logic        RSTBTN;
	logic [3:0]  sw;
	logic        hsync;
	logic        vsync;
	logic        de;
	pixel_t      pixel;
	fmt_code_t   fmt_status;
	logic        act_lvl;    // Active sync level of the format in use
	logic [31:0] lfsr_state;

	// Monitor state written at negedge only
	logic      de_q, hs_on_q, vs_on_q, skip, vs_seen;
	fmt_code_t fmt_q;
	int        gap_cnt, hs_run, vs_run, lines_cnt, de_idx, since_chg;
	int        line_len, de_len, hs_len, vs_len, frame_lines;
	int        n_line, n_de, n_hs, n_vs, n_frame;

	video_timing_top dut_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.pixel       (pixel),
		.fmt_status  (fmt_status)
	);

	always #10 clk50m_bufg = !clk50m_bufg; // 50 MHz

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output int val);
		int i;
		val = 0;
		for (i = 0; i < n; i++) begin
			val        = (val << 1) | lfsr_state[0]; // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Bar order white yellow cyan green magenta red blue black
	function automatic pixel_t bar_color_of(input int n);
		logic [2:0] rgb;
		pixel_t     p;
		case ((n >> BAR_SHIFT) % 8)
			0:       rgb = 3'b111;
			1:       rgb = 3'b110;
			2:       rgb = 3'b011;
			3:       rgb = 3'b010;
			4:       rgb = 3'b101;
			5:       rgb = 3'b100;
			6:       rgb = 3'b001;
			default: rgb = 3'b000;
		endcase
		p.red   = {8{rgb[2]}};
		p.green = {8{rgb[1]}};
		p.blue  = {8{rgb[0]}};
		return p;
	endfunction

	function automatic logic is_known(input fmt_code_t c);
		return c == FMT_VGA || c == FMT_SVGA || c == FMT_XGA ||
			c == FMT_HDTV720P || c == FMT_SXGA || c == FMT_CAMERA;
	endfunction

	function automatic int event_count(input int which);
		case (which)
			EV_LINE: return n_line;
			EV_DE:   return n_de;
			EV_HS:   return n_hs;
			EV_VS:   return n_vs;
			default: return n_frame;
		endcase
	endfunction

	task automatic wait_events(input int which, input int n, input int limit, input string what);
		int start;
		int waited;
		start  = event_count(which);
		waited = 0;
		while (event_count(which) < start + n) begin
			@(posedge clk50m_bufg);
			waited++;
			if (waited > limit)
				report_timeout(what);
		end
	endtask

	task automatic wait_format(input fmt_code_t code);
		int waited;
		waited = 0;
		while (fmt_status != code) begin
			@(posedge clk50m_bufg);
			waited++;
			if (waited > (1 << DEBOUNCE_BITS) + 64)
				report_timeout("the switch setting to reach fmt_status");
		end
	endtask

	// Third event is clean even across a format change
	task automatic check_line(input video_timing_t t, input string name);
		wait_events(EV_LINE, 3, 200000, {name, " de rising edges"});
		assert (line_len == t.heblnk + 1)
			else report_error($sformatf("%s line is %0d cycles", name, line_len));
		wait_events(EV_DE, 3, 200000, {name, " de runs"});
		assert (de_len == t.hsblnk + 1)
			else report_error($sformatf("%s de lasts %0d cycles", name, de_len));
		wait_events(EV_HS, 3, 20000, {name, " hsync pulses"});
		assert (hs_len == t.hesync - t.hssync)
			else report_error($sformatf("%s hsync pulse is %0d cycles", name, hs_len));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk50m_bufg) begin : monitor
		logic hs_on;
		logic vs_on;
		hs_on = (hsync == act_lvl);
		vs_on = (vsync == act_lvl);
		if (RSTBTN) begin
			{de_q, hs_on_q, vs_on_q, vs_seen} = '0;
			skip  = 1'b1; // First line after reset not checked
			fmt_q = fmt_status;
			{gap_cnt, hs_run, vs_run, lines_cnt, de_idx, since_chg} = '0;
			{n_line, n_de, n_hs, n_vs, n_frame} = '0;
		end else begin
			since_chg++;
			if (fmt_status != fmt_q) begin
				skip      = 1'b1; // Pipeline holds old and new raster
				since_chg = 0;
			end
			fmt_q = fmt_status;
			if (de && !de_q) begin // Line start
				if (!vs_seen) begin
					line_len = gap_cnt;
					n_line++;
				end
				vs_seen   = 1'b0;
				gap_cnt   = 1;
				lines_cnt++;
				de_idx    = 0;
				if (since_chg > 8)
					skip = 1'b0;
			end else begin
				gap_cnt++;
			end
			if (!de && de_q) begin
				de_len = de_idx;
				n_de++;
			end
			if (!skip) begin
				if (de) begin
					assert (pixel == bar_color_of(de_idx))
						else report_error($sformatf("pixel %h at de index %0d", pixel, de_idx));
				end else begin
					assert (pixel == '0)
						else report_error($sformatf("pixel %h outside de", pixel));
				end
				assert (!de || (!hs_on && !vs_on))
					else report_error("sync active while de is high");
			end
			if (de) begin
				de_idx++;
			end
			if (hs_on) begin
				hs_run = hs_on_q ? hs_run + 1 : 1;
			end else if (hs_on_q) begin
				hs_len = hs_run;
				n_hs++;
			end
			if (vs_on && !vs_on_q) begin // Frame boundary
				frame_lines = lines_cnt;
				lines_cnt   = 0;
				vs_seen     = 1'b1;
				n_frame++;
			end
			if (vs_on) begin
				vs_run = vs_on_q ? vs_run + 1 : 1;
			end else if (vs_on_q) begin
				vs_len = vs_run;
				n_vs++;
			end
			de_q    = de;
			hs_on_q = hs_on;
			vs_on_q = vs_on;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		video_timing_t t720;
		video_timing_t tvga;
		fmt_code_t     code;
		fmt_code_t     last;
		int            r;
		int            gap;
		int            k;
		t720        = fmt_timing(FMT_HDTV720P);
		tvga        = fmt_timing(FMT_VGA);
		clk50m_bufg = 1'b0;
		RSTBTN      = 1'b1;
		sw          = FMT_HDTV720P; // Matches the boot format
		lfsr_state  = 32'h68de744d;
		act_lvl     = !t720.neg_polarity;
		repeat (2) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
		@(posedge clk50m_bufg);

		// Reset values
		assert (!de && hsync == t720.neg_polarity && vsync == t720.neg_polarity)
			else report_error($sformatf("after reset de %b hsync %b vsync %b", de, hsync, vsync));
		assert (fmt_status == FMT_HDTV720P)
			else report_error($sformatf("after reset fmt_status is %b", fmt_status));

		check_line(t720, "720p");

		// Over to VGA with negative syncs
		sw <= FMT_VGA;
		wait_format(FMT_VGA);
		act_lvl <= !tvga.neg_polarity;
		check_line(tvga, "VGA");
		wait_events(EV_LINE, 1, 100000, "a VGA line");
		assert (hsync == tvga.neg_polarity)
			else report_error($sformatf("VGA hsync idles at %b", hsync));
		wait_events(EV_FRAME, 2, 1000000, "two VGA vsync pulses");
		assert (frame_lines == tvga.vsblnk + 1)
			else report_error($sformatf("VGA frame has %0d de lines", frame_lines));
		wait_events(EV_VS, 1, 10000, "the end of a VGA vsync pulse");
		assert (vs_len == (tvga.vesync - tvga.vssync) * (tvga.heblnk + 1))
			else report_error($sformatf("VGA vsync pulse is %0d cycles", vs_len));

		// Bounce with each code held too briefly to settle
		last = FMT_VGA;
		for (k = 0; k < 6; k++) begin
			draw_bits(4, r);
			code = fmt_code_t'(r);
			if (code == last)
				code = code ^ 4'b0001;
			draw_bits(15, r);
			gap  = r + 1;
			sw  <= code;
			last = code;
			repeat (gap) begin
				@(posedge clk50m_bufg);
				assert (fmt_status == FMT_VGA)
					else report_error($sformatf("bounce moved fmt_status to %b", fmt_status));
			end
		end

		// Unknown code held steady
		draw_bits(4, r);
		code = fmt_code_t'(r);
		while (is_known(code))
			code = code + 1'b1;
		sw <= code;
		wait_format(code);
		act_lvl <= !t720.neg_polarity; // Unknown codes run as 720p
		check_line(t720, "fallback");

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: video_fmt_pkg.sv
package video_fmt_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Switch codes and widths
	////////////////////////////////////////////////////////////////////////////
	typedef logic [3:0] fmt_code_t;

	localparam fmt_code_t FMT_VGA     = 4'b0000; // 640x480
	localparam fmt_code_t FMT_SVGA    = 4'b0001; // 800x600
	localparam fmt_code_t FMT_XGA     = 4'b0011; // 1024x768
	localparam fmt_code_t FMT_HDTV720P = 4'b0010; // 1280x720, also the fallback
	localparam fmt_code_t FMT_SXGA    = 4'b1000; // 1280x1024
	localparam fmt_code_t FMT_CAMERA  = 4'b1001; // 720p variant with odd porches

	localparam int CNT_W         = 11; // Raster counter width
	localparam int DEBOUNCE_BITS = 16; // 2^16 stable cycles, ~1.3 ms at 50 MHz
	localparam int BAR_SHIFT     = 7;  // 128 pixel wide bars

	// Compare points, all as the last count of a region
	typedef struct packed {
		logic [CNT_W-1:0] hsblnk; // Last active pixel
		logic [CNT_W-1:0] hssync; // Hsync starts after this
		logic [CNT_W-1:0] hesync; // Last hsync pixel
		logic [CNT_W-1:0] heblnk; // Last pixel of the line
		logic [CNT_W-1:0] vsblnk;
		logic [CNT_W-1:0] vssync;
		logic [CNT_W-1:0] vesync;
		logic [CNT_W-1:0] veblnk;
		logic             neg_polarity; // Syncs idle high
	} video_timing_t;

	typedef struct packed {
		logic [CNT_W-1:0] hcount;
		logic [CNT_W-1:0] vcount;
		logic             hblnk;
		logic             vblnk;
		logic             hsync; // Raw, active high
		logic             vsync;
	} raster_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	////////////////////////////////////////////////////////////////////////////
	// Timing table
	////////////////////////////////////////////////////////////////////////////
	// Active size, front porch, sync width, back porch per direction
	function automatic video_timing_t make_timing(input int pix_h, input int fp_h,
		input int sw_h, input int bp_h, input int lin_v, input int fp_v,
		input int sw_v, input int bp_v, input logic neg);
		video_timing_t t;
		t.hsblnk       = CNT_W'(pix_h - 1);
		t.hssync       = CNT_W'(pix_h - 1 + fp_h);
		t.hesync       = CNT_W'(pix_h - 1 + fp_h + sw_h);
		t.heblnk       = CNT_W'(pix_h - 1 + fp_h + sw_h + bp_h);
		t.vsblnk       = CNT_W'(lin_v - 1);
		t.vssync       = CNT_W'(lin_v - 1 + fp_v);
		t.vesync       = CNT_W'(lin_v - 1 + fp_v + sw_v);
		t.veblnk       = CNT_W'(lin_v - 1 + fp_v + sw_v + bp_v);
		t.neg_polarity = neg;
		return t;
	endfunction

	function automatic video_timing_t fmt_timing(input fmt_code_t code);
		case (code)
			FMT_VGA:    return make_timing( 640,  16,  96,  48, 480, 11, 2, 31, 1'b1);
			FMT_SVGA:   return make_timing( 800,  40, 128,  88, 600,  1, 4, 23, 1'b0);
			FMT_XGA:    return make_timing(1024,  24, 136, 160, 768,  3, 6, 29, 1'b1);
			FMT_SXGA:   return make_timing(1280,  48, 112, 248, 1024, 1, 3, 38, 1'b0);
			FMT_CAMERA: return make_timing(1280, 110,  39, 220, 720,  4, 4, 22, 1'b0);
			default:    return make_timing(1280, 110,  40, 220, 720,  5, 5, 20, 1'b0);
		endcase
	endfunction

endpackage

// File: video_out.sv
`timescale 1ns/1ps

module video_out (
	input  logic                   clk50m_bufg,
	input  logic                   RSTBTN,
	input  video_fmt_pkg::raster_t raster,
	input  logic                   neg_polarity, // 1 flips both syncs
	output logic                   hsync,
	output logic                   vsync,
	output logic                   de,           // Data enable
	output video_fmt_pkg::pixel_t  pixel
);

	import video_fmt_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Bar pattern
	////////////////////////////////////////////////////////////////////////////
	logic [2:0] bar_idx;   // hcount / 128, modulo 8
	pixel_t     bar_color;

	assign bar_idx = raster.hcount[BAR_SHIFT +: 3];

	always_comb begin
		case (bar_idx)
			3'd0:    bar_color = {8'hff, 8'hff, 8'hff}; // White
			3'd1:    bar_color = {8'hff, 8'hff, 8'h00}; // Yellow
			3'd2:    bar_color = {8'h00, 8'hff, 8'hff}; // Cyan
			3'd3:    bar_color = {8'h00, 8'hff, 8'h00}; // Green
			3'd4:    bar_color = {8'hff, 8'h00, 8'hff}; // Magenta
			3'd5:    bar_color = {8'hff, 8'h00, 8'h00}; // Red
			3'd6:    bar_color = {8'h00, 8'h00, 8'hff}; // Blue
			default: bar_color = {8'h00, 8'h00, 8'h00}; // Black
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, polarity and active
	////////////////////////////////////////////////////////////////////////////
	logic   active_s1;
	logic   hsync_s1;
	logic   vsync_s1;
	pixel_t color_s1;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			active_s1 <= 1'b0;
			hsync_s1  <= 1'b0; // Inactive for 720p
			vsync_s1  <= 1'b0;
		end else begin
			active_s1 <= !raster.hblnk && !raster.vblnk;
			hsync_s1  <= raster.hsync ^ neg_polarity;
			vsync_s1  <= raster.vsync ^ neg_polarity;
		end
	end

	always_ff @(posedge clk50m_bufg)
		color_s1 <= bar_color; // Masked in stage 2

	////////////////////////////////////////////////////////////////////////////
	// Stage 2, output registers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de    <= 1'b0;
			pixel <= '0;
		end else begin
			hsync <= hsync_s1;
			vsync <= vsync_s1;
			de    <= active_s1;
			pixel <= active_s1 ? color_s1 : '0; // Black in blanking
		end
	end

endmodule

// File: video_timing_top.sv
`timescale 1ns/1ps

module video_timing_top (
	input  logic                     clk50m_bufg, // Doubles as pixel clock
	input  logic                     RSTBTN,
	input  logic [3:0]               sw,          // Format select switches
	output logic                     hsync,
	output logic                     vsync,
	output logic                     de,
	output video_fmt_pkg::pixel_t    pixel,
	output video_fmt_pkg::fmt_code_t fmt_status   // Format in use
);

	import video_fmt_pkg::*;

	fmt_code_t fmt_sel;
	logic      fmt_change;
	raster_t   raster;
	logic      neg_polarity;

	// Switches in, settled format out
	format_switch format_switch_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.fmt_sel     (fmt_sel),
		.fmt_change  (fmt_change)
	);

	// Counters, blanking, raw sync
	raster_gen raster_gen_i (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.fmt_sel      (fmt_sel),
		.fmt_change   (fmt_change),
		.raster       (raster),
		.neg_polarity (neg_polarity)
	);

	// Two cycles to the pins
	video_out video_out_i (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.raster       (raster),
		.neg_polarity (neg_polarity),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.pixel        (pixel)
	);

	assign fmt_status = fmt_sel;

endmodule
